// File: filelist.f
design/led_matrix_pkg.sv
design/row_fetch_if.sv
design/uart_byte_rx.sv
design/command_parser.sv
design/display_regs.sv
design/framebuffer_ram.sv
design/row_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
bench/tb_led_matrix.sv

// File: bench/tb_led_matrix.sv
`timescale 1ns/1ps
/* drives led_matrix_top over its UART input and checks the shifted bit planes
   against a frame model; checks run only on rows scanned fully after the model settled */
module tb_led_matrix import led_matrix_pkg::*; ();

    localparam int TICKS_PER_BIT = 8;
    localparam int BASE_ON_TIME  = 4;
    localparam int NUM_TESTS     = 6;
    localparam int FRAME_LATCHES = SCAN_ROWS * COLOR_BITS;
    // upper bound per frame covering fetch, four shifts, latches and on-times per row pair
    localparam int FRAME_CLKS    = SCAN_ROWS * (3 * COLUMNS + COLOR_BITS * (2 * COLUMNS + 2)
                                   + BASE_ON_TIME * (2 ** COLOR_BITS));
    localparam int WATCHDOG_CLKS = NUM_TESTS * 8 * FRAME_CLKS;

    logic      clk_root;
    logic      rst_n;
    logic      uart_rx;
    rgb_t      rgb_top;
    rgb_t      rgb_bottom;
    scan_row_t row_addr;
    logic      pixel_clk;
    logic      latch;
    logic      oe_n;

    color_t      model_fb [FB_DEPTH];
    rgb_t        model_chan_en;
    plane_mask_t model_plane_en;
    logic        settled;       // model and DUT agree from here on

    int   latch_cnt;            // latches since reset
    int   pulse_cnt;
    int   on_len;
    int   cur_plane;
    int   rows_checked;
    logic row_bad;
    logic row_armed;
    int   bad_row;
    int   bad_plane;
    int   bad_col;
    logic [5:0] bad_got;        // {bottom, top}
    logic [5:0] bad_exp;
    int   errors = 0;
    int   test_idx;
    int   test_start_errors;

    led_matrix_top #(
        .TICKS_PER_BIT(TICKS_PER_BIT),
        .BASE_ON_TIME(BASE_ON_TIME)
    ) i_dut (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .uart_rx(uart_rx),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .row_addr(row_addr),
        .pixel_clk(pixel_clk),
        .latch(latch),
        .oe_n(oe_n)
    );

    initial begin
        clk_root = 1'b0;
        forever #5 clk_root = ~clk_root;
    end

    // one bit of plane p per channel, masked by the model enables
    function automatic rgb_t expected_bits(color_t px, int p);
        rgb_t bits;
        bits = {px.b[p], px.g[p], px.r[p]};
        if (!model_plane_en[p]) begin
            bits = '0;
        end
        return bits & model_chan_en;
    endfunction

    function automatic color_t random_color();
        return color_t'(12'($urandom));
    endfunction

    always @(posedge clk_root) begin
        rgb_t exp_top;
        rgb_t exp_bot;
        int   row;
        int   plane;
        int   col;
        plane = latch_cnt % COLOR_BITS;
        row   = (latch_cnt / COLOR_BITS) % SCAN_ROWS;
        col   = pulse_cnt % COLUMNS;
        if (!rst_n) begin
            latch_cnt    <= 0;
            pulse_cnt    <= 0;
            on_len       <= 0;
            cur_plane    <= 0;
            rows_checked <= 0;
            row_bad      <= 1'b0;
            row_armed    <= 1'b0;
        end else begin
            if (pixel_clk) begin
                exp_top   = expected_bits(model_fb[row * COLUMNS + col], plane);
                exp_bot   = expected_bits(model_fb[(row + SCAN_ROWS) * COLUMNS + col], plane);
                pulse_cnt <= pulse_cnt + 1;
                if (!row_bad && (rgb_top !== exp_top || rgb_bottom !== exp_bot)) begin
                    row_bad   <= 1'b1;      // keep the first bad column of the row
                    bad_row   <= row;
                    bad_plane <= plane;
                    bad_col   <= col;
                    bad_got   <= {rgb_bottom, rgb_top};
                    bad_exp   <= {exp_bot, exp_top};
                end
            end
            if (latch) begin
                latch_cnt <= latch_cnt + 1;
                cur_plane <= plane;
                pulse_cnt <= 0;
                row_bad   <= 1'b0;
                row_armed <= settled;     // next row is compared only if settled throughout
                if (row_armed && settled) begin
                    rows_checked <= rows_checked + 1;
                end
            end
            on_len <= oe_n ? 0 : on_len + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk_root)
        $rose(rst_n) |-> !pixel_clk && !latch && oe_n)
        else begin
            errors++;
            $display("MISMATCH at %0t: pixel_clk, latch or oe_n not idle after reset", $time);
        end

    a_dark_shift: assert property (@(posedge clk_root) disable iff (!rst_n)
        !oe_n |-> !pixel_clk && !latch)
        else begin
            errors++;
            $display("MISMATCH at %0t: oe_n low while pixel_clk or latch high", $time);
        end

    a_on_time: assert property (@(posedge clk_root) disable iff (!rst_n)
        (oe_n && on_len != 0) |-> on_len == (BASE_ON_TIME << cur_plane))
        else begin
            errors++;
            $display("MISMATCH at %0t: oe_n low stretch for plane %0d is not %0d clocks",
                     $time, cur_plane, BASE_ON_TIME << cur_plane);
        end

    a_pulses: assert property (@(posedge clk_root) disable iff (!rst_n)
        latch |-> pulse_cnt == COLUMNS)
        else begin
            errors++;
            $display("MISMATCH at %0t: pixel_clk pulses before latch differ from %0d",
                     $time, COLUMNS);
        end

    a_row_step: assert property (@(posedge clk_root) disable iff (!rst_n)
        latch |-> row_addr == scan_row_t'(latch_cnt / COLOR_BITS))
        else begin
            errors++;
            $display("MISMATCH at %0t: row_addr %0d at latch, expected %0d", $time,
                     $sampled(row_addr), scan_row_t'($sampled(latch_cnt) / COLOR_BITS));
        end

    a_row_data: assert property (@(posedge clk_root) disable iff (!rst_n)
        (latch && row_armed && settled) |-> !row_bad)
        else begin
            errors++;
            $display("MISMATCH at %0t: row %0d plane %0d column %0d got %b expected %b",
                     $time, bad_row, bad_plane, bad_col, bad_got, bad_exp);
        end

    // 8N1 frame with one bit per TICKS_PER_BIT clocks
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_root);
            uart_rx <= frame[i];
            repeat (TICKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic fill_frame(input color_t c);
        settled <= 1'b0;
        send_byte(OP_FILL);
        send_byte({c.r, c.g});
        send_byte({4'($urandom), c.b});     // high nibble ignored
        foreach (model_fb[i]) begin
            model_fb[i] = c;
        end
        repeat (2050) @(posedge clk_root);
    endtask

    task automatic write_pixel(input logic [7:0] x, input logic [7:0] y, input color_t c);
        settled <= 1'b0;
        send_byte(OP_PIXEL);
        send_byte(x);
        send_byte(y);
        send_byte({c.r, c.g});
        send_byte({4'($urandom), c.b});
        model_fb[{y[4:0], x[5:0]}] = c;
    endtask

    task automatic write_channel_mask(input rgb_t m);
        settled <= 1'b0;
        send_byte(OP_ENABLE);
        send_byte({5'($urandom), m});
        model_chan_en = m;
    endtask

    task automatic write_plane_mask(input plane_mask_t m);
        settled <= 1'b0;
        send_byte(OP_PLANES);
        send_byte({4'($urandom), m});
        model_plane_en = m;
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = latch_cnt + n;
        while (latch_cnt < target) begin
            @(posedge clk_root);
        end
    endtask

    task automatic settle_and_observe();
        wait_latches(2 * FRAME_LATCHES);
        @(posedge clk_root);
        settled <= 1'b1;
        wait_latches(FRAME_LATCHES + COLOR_BITS);   // first row after arming is skipped
    endtask

    task automatic end_test(input string name);
        test_idx++;
        $display("test %0d %s: %s, %0d errors", test_idx, name,
                 (errors == test_start_errors) ? "ok" : "failed", errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        test_idx          = 0;
        test_start_errors = 0;
        settled           = 1'b0;
        model_chan_en     = '1;
        model_plane_en    = '1;
        rst_n             = 1'b0;
        uart_rx           = 1'b1;
        void'($urandom(32'heabd_34f3));
        repeat (16) @(posedge clk_root);
        rst_n <= 1'b1;

        fill_frame(random_color());
        settle_and_observe();
        end_test("reset state and fill");

        write_pixel({2'($urandom), 6'd63}, {3'($urandom), 5'd31}, random_color());
        write_pixel(8'd0, 8'd0, random_color());
        for (int i = 0; i < 4; i++) begin
            write_pixel(8'($urandom), {3'($urandom), i[0], 4'($urandom)}, random_color());
        end
        settle_and_observe();
        end_test("pixel writes");

        write_channel_mask(3'($urandom));
        settle_and_observe();
        end_test("channel enable");

        write_channel_mask(3'b111);
        write_plane_mask(4'($urandom));
        settle_and_observe();
        end_test("plane enable");

        wait_latches(FRAME_LATCHES);    // timing properties only
        end_test("scan timing");

        write_plane_mask(4'hf);
        settled <= 1'b0;
        send_byte(8'h58);               // not an opcode
        write_pixel(8'($urandom), 8'($urandom), random_color());
        settle_and_observe();
        end_test("unknown opcode");

        $display("summary: %0d tests, %0d row pairs compared, %0d errors",
                 test_idx, rows_checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk_root);
        $display("timeout: tests did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: design/led_matrix_top.sv
`timescale 1ns/1ps
/* HUB75 driver for a 64 x 32 panel fed by an 8N1 UART command stream
   single clock domain; uart_rx needs no external synchroniser */
module led_matrix_top import led_matrix_pkg::*; #(
    parameter int TICKS_PER_BIT = 8,
    parameter int BASE_ON_TIME  = 4
) (
    input  logic      clk_root,
    input  logic      rst_n,
    input  logic      uart_rx,
    output rgb_t      rgb_top,
    output rgb_t      rgb_bottom,
    output scan_row_t row_addr,
    output logic      pixel_clk,
    output logic      latch,
    output logic      oe_n
);

    logic        [7:0] rx_data;
    logic              rx_valid;
    logic              wr_en;
    fb_addr_t          wr_addr;
    color_t            wr_data;
    logic              reg_we;
    reg_sel_t          reg_sel;
    logic        [7:0] reg_data;
    rgb_t              rgb_enable;
    plane_mask_t       plane_enable;
    fb_addr_t          rd_addr;
    color_t            rd_data;

    row_fetch_if fetch_link ();

    uart_byte_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) i_uart_rx (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .rx(uart_rx),
        .rx_data(rx_data),
        .rx_valid(rx_valid)
    );

    command_parser i_parser (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .reg_we(reg_we),
        .reg_sel(reg_sel),
        .reg_data(reg_data)
    );

    display_regs i_regs (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .reg_we(reg_we),
        .reg_sel(reg_sel),
        .reg_data(reg_data),
        .rgb_enable(rgb_enable),
        .plane_enable(plane_enable)
    );

    framebuffer_ram i_fb (
        .clk_root(clk_root),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    row_fetch i_fetch (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .fetch(fetch_link.fetch)
    );

    matrix_scan #(
        .BASE_ON_TIME(BASE_ON_TIME)
    ) i_scan (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .rgb_enable(rgb_enable),
        .plane_enable(plane_enable),
        .scan(fetch_link.scan),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .row_addr(row_addr),
        .pixel_clk(pixel_clk),
        .latch(latch),
        .oe_n(oe_n)
    );

endmodule

// File: design/matrix_scan.sv
`timescale 1ns/1ps
/* each row pair is fetched, then planes 0..3 are shifted 64 columns each, latched
   and lit for BASE_ON_TIME << plane clocks; oe_n stays high outside the on-time */
module matrix_scan import led_matrix_pkg::*; #(
    parameter int BASE_ON_TIME = 4
) (
    input  logic        clk_root,
    input  logic        rst_n,
    input  rgb_t        rgb_enable,
    input  plane_mask_t plane_enable,
    row_fetch_if.scan   scan,
    output rgb_t        rgb_top,
    output rgb_t        rgb_bottom,
    output scan_row_t   row_addr,
    output logic        pixel_clk,
    output logic        latch,
    output logic        oe_n
);

    localparam int MAX_ON = BASE_ON_TIME * (2 ** (COLOR_BITS - 1));
    localparam int ON_W   = $clog2(MAX_ON + 1);

    typedef enum logic [2:0] {ST_FETCH, ST_DATA, ST_CLK, ST_LATCH, ST_ON} state_t;

    state_t          state;
    scan_row_t       row;       // row pair being loaded and shifted
    plane_t          plane;
    col_t            col;
    logic            req;
    logic [ON_W-1:0] on_cnt;

    // bit p of each channel, gated by channel and plane enables
    function automatic rgb_t shade(color_t px, plane_t p, rgb_t chan_en, plane_mask_t pl_en);
        rgb_t bits;
        bits[0] = px.r[p];
        bits[1] = px.g[p];
        bits[2] = px.b[p];
        return bits & chan_en & {3{pl_en[p]}};
    endfunction

    assign scan.req    = req;
    assign scan.row    = row;
    assign scan.column = col;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state      <= ST_FETCH;
            row        <= '0;
            plane      <= '0;
            col        <= '0;
            req        <= 1'b0;
            on_cnt     <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
            row_addr   <= '0;
            pixel_clk  <= 1'b0;
            latch      <= 1'b0;
            oe_n       <= 1'b1;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!req) begin
                        if (!scan.ack) begin
                            req <= 1'b1;    // previous load fully released
                        end
                    end else if (scan.ack) begin
                        req   <= 1'b0;
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    rgb_top    <= shade(scan.pixel_top, plane, rgb_enable, plane_enable);
                    rgb_bottom <= shade(scan.pixel_bottom, plane, rgb_enable, plane_enable);
                    pixel_clk  <= 1'b0;
                    state      <= ST_CLK;
                end
                ST_CLK: begin
                    pixel_clk <= 1'b1;
                    col       <= col + 1'b1;    // wraps to 0 after the last column
                    state     <= (col == col_t'(COLUMNS - 1)) ? ST_LATCH : ST_DATA;
                end
                ST_LATCH: begin
                    pixel_clk <= 1'b0;
                    latch     <= 1'b1;
                    row_addr  <= row;
                    on_cnt    <= ON_W'(BASE_ON_TIME << plane);
                    state     <= ST_ON;
                end
                default: begin
                    latch <= 1'b0;
                    if (on_cnt == '0) begin
                        oe_n  <= 1'b1;
                        plane <= plane + 1'b1;
                        if (plane == plane_t'(COLOR_BITS - 1)) begin
                            row   <= row + 1'b1;
                            state <= ST_FETCH;
                        end else begin
                            state <= ST_DATA;
                        end
                    end else begin
                        oe_n   <= 1'b0;     // weighted on-time
                        on_cnt <= on_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/row_fetch.sv
`timescale 1ns/1ps
/* copies row pair {row, row + 16} into two line buffers on req
   req to ack takes 2 * COLUMNS + 2 clocks; buffers must not be read before ack */
module row_fetch import led_matrix_pkg::*; (
    input  logic       clk_root,
    input  logic       rst_n,
    output fb_addr_t   rd_addr,
    input  color_t     rd_data,
    row_fetch_if.fetch fetch
);

    localparam int IDX_W = $clog2(2 * COLUMNS);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_DRAIN, ST_ACK} state_t;

    state_t           state;
    logic [IDX_W-1:0] rd_idx;     // top bit selects the bottom half
    logic [IDX_W-1:0] wr_idx;
    logic             rd_valid;
    logic             ack;
    color_t           line_top [COLUMNS];
    color_t           line_bottom [COLUMNS];

    // y = {half, row}, so the half bit lands above the row pair index
    assign rd_addr = {rd_idx[IDX_W-1], fetch.row, rd_idx[IDX_W-2:0]};

    assign fetch.ack          = ack;
    assign fetch.pixel_top    = line_top[fetch.column];
    assign fetch.pixel_bottom = line_bottom[fetch.column];

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            rd_idx   <= '0;
            rd_valid <= 1'b0;
            ack      <= 1'b0;
        end else begin
            rd_valid <= (state == ST_READ);
            case (state)
                ST_IDLE: begin
                    rd_idx <= '0;
                    if (fetch.req) begin
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    rd_idx <= rd_idx + 1'b1;
                    if (rd_idx == IDX_W'(2 * COLUMNS - 1)) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    ack   <= 1'b1;    // last word is written this clock
                    state <= ST_ACK;
                end
                default: begin
                    if (!fetch.req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // write side trails the read address by the RAM latency
    always_ff @(posedge clk_root) begin
        wr_idx <= rd_idx;
        if (rd_valid) begin
            if (wr_idx[IDX_W-1]) begin
                line_bottom[wr_idx[IDX_W-2:0]] <= rd_data;
            end else begin
                line_top[wr_idx[IDX_W-2:0]] <= rd_data;
            end
        end
    end

endmodule

// File: design/framebuffer_ram.sv
`timescale 1ns/1ps
/* 2048 x 12 frame store, contents undefined after power-up
   read is registered; a read of the address being written returns the old word */
module framebuffer_ram import led_matrix_pkg::*; (
    input  logic     clk_root,
    input  logic     wr_en,
    input  fb_addr_t wr_addr,
    input  color_t   wr_data,
    input  fb_addr_t rd_addr,
    output color_t   rd_data
);

    color_t mem [FB_DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];    // one clock of latency
    end

endmodule

// File: design/display_regs.sv
`timescale 1ns/1ps
/* display settings, all channels and all planes enabled out of reset */
module display_regs import led_matrix_pkg::*; (
    input  logic        clk_root,
    input  logic        rst_n,
    input  logic        reg_we,
    input  reg_sel_t    reg_sel,
    input  logic [7:0]  reg_data,
    output rgb_t        rgb_enable,
    output plane_mask_t plane_enable
);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else if (reg_we) begin
            case (reg_sel)
                REG_RGB_ENABLE:   rgb_enable   <= reg_data[$bits(rgb_t)-1:0];
                REG_PLANE_ENABLE: plane_enable <= reg_data[COLOR_BITS-1:0];
                default: ;
            endcase
        end
    end

endmodule

// File: design/command_parser.sv
`timescale 1ns/1ps
/* byte-stream decoder; unknown opcodes are skipped, bytes arriving
   during a fill (2048 clocks) are dropped */
module command_parser import led_matrix_pkg::*; (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       wr_en,
    output fb_addr_t   wr_addr,
    output color_t     wr_data,
    output logic       reg_we,
    output reg_sel_t   reg_sel,
    output logic [7:0] reg_data
);

    typedef enum logic [2:0] {
        ST_OPCODE, ST_X, ST_Y, ST_COLOR0, ST_COLOR1, ST_ARG, ST_FILL
    } state_t;

    state_t     state;
    cmd_op_t    op;
    col_t       x;
    y_t         y;
    logic [7:0] color_hi;   // red and green nibbles

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state  <= ST_OPCODE;
            wr_en  <= 1'b0;
            reg_we <= 1'b0;
        end else begin
            wr_en  <= 1'b0;
            reg_we <= 1'b0;
            if (state == ST_FILL) begin
                if (wr_addr == '1) begin
                    state <= ST_OPCODE;   // last address written this clock
                end else begin
                    wr_en <= 1'b1;
                end
            end else if (rx_valid) begin
                case (state)
                    ST_OPCODE: begin
                        case (rx_data)
                            OP_PIXEL:             state <= ST_X;
                            OP_FILL:              state <= ST_COLOR0;
                            OP_ENABLE, OP_PLANES: state <= ST_ARG;
                            default:              state <= ST_OPCODE;
                        endcase
                    end
                    ST_X:      state <= ST_Y;
                    ST_Y:      state <= ST_COLOR0;
                    ST_COLOR0: state <= ST_COLOR1;
                    ST_COLOR1: begin
                        wr_en <= 1'b1;
                        state <= (op == OP_FILL) ? ST_FILL : ST_OPCODE;
                    end
                    default: begin          // settings byte
                        reg_we <= 1'b1;
                        state  <= ST_OPCODE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            case (state)
                ST_OPCODE: op       <= cmd_op_t'(rx_data);
                ST_X:      x        <= rx_data[$bits(col_t)-1:0];
                ST_Y:      y        <= rx_data[$bits(y_t)-1:0];
                ST_COLOR0: color_hi <= rx_data;
                ST_COLOR1: begin
                    wr_addr <= (op == OP_FILL) ? '0 : {y, x};
                    wr_data <= {color_hi, rx_data[3:0]};
                end
                ST_ARG: begin
                    reg_sel  <= (op == OP_ENABLE) ? REG_RGB_ENABLE : REG_PLANE_ENABLE;
                    reg_data <= rx_data;
                end
                default: ;
            endcase
        end
        if (state == ST_FILL) begin
            wr_addr <= wr_addr + 1'b1;  // fill address counter
        end
    end

endmodule

// File: design/uart_byte_rx.sv
`timescale 1ns/1ps
/* 8N1 receiver, LSB first, idle high; needs TICKS_PER_BIT >= 4
   sampling runs one clock ahead of mid-bit to offset the synchroniser delay */
module uart_byte_rx #(
    parameter int TICKS_PER_BIT = 8
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CNT_W      = $clog2(TICKS_PER_BIT);
    localparam int START_WAIT = TICKS_PER_BIT / 2 - 2;

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} state_t;

    state_t           state;
    logic             rx_meta;
    logic             rx_s;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_idx;
    logic             bit_tick;

    assign bit_tick = (tick_cnt == CNT_W'(TICKS_PER_BIT - 1));

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_s) begin
                        state <= ST_START;    // falling start edge
                    end
                end
                ST_START: begin
                    if (tick_cnt == CNT_W'(START_WAIT)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_s ? ST_IDLE : ST_DATA;   // glitch if high again
                    end
                end
                ST_DATA: begin
                    if (bit_tick) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_tick) begin
                        rx_valid <= rx_s;     // bad stop bit, frame dropped
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == ST_DATA && bit_tick) begin
            rx_data <= {rx_s, rx_data[7:1]};
        end
    end

endmodule

// File: design/row_fetch_if.sv
`timescale 1ns/1ps
/* four-phase row load between scanner and fetcher
   pixel data is only valid from ack rising until the next req rising */
interface row_fetch_if import led_matrix_pkg::*; ();

    logic      req;
    logic      ack;
    scan_row_t row;           // held stable while req is high
    col_t      column;
    color_t    pixel_top;     // follows column combinationally
    color_t    pixel_bottom;

    modport scan (output req, row, column, input ack, pixel_top, pixel_bottom);

    modport fetch (input req, row, column, output ack, pixel_top, pixel_bottom);

endinterface

// File: design/led_matrix_pkg.sv
/* geometry and shared types for a 64 x 32 HUB75 panel scanned as 16 row pairs
   framebuffer address is {y, x}; colour is 4 bits per channel, red in the top field */
package led_matrix_pkg;

    localparam int COLUMNS    = 64;
    localparam int SCAN_ROWS  = 16;
    localparam int PANEL_ROWS = 32;
    localparam int COLOR_BITS = 4;
    localparam int FB_DEPTH   = COLUMNS * PANEL_ROWS;

    typedef logic [$clog2(COLUMNS)-1:0]    col_t;
    typedef logic [$clog2(SCAN_ROWS)-1:0]  scan_row_t;
    typedef logic [$clog2(PANEL_ROWS)-1:0] y_t;
    typedef logic [$bits(y_t)+$bits(col_t)-1:0] fb_addr_t;

    typedef struct packed {
        logic [COLOR_BITS-1:0] r;
        logic [COLOR_BITS-1:0] g;
        logic [COLOR_BITS-1:0] b;
    } color_t;

    typedef logic [$clog2(COLOR_BITS)-1:0] plane_t;
    typedef logic [COLOR_BITS-1:0]         plane_mask_t;
    typedef logic [2:0]                    rgb_t;     // [0] red, [1] green, [2] blue

    typedef enum logic [7:0] {
        OP_PIXEL  = 8'h50,  // 'P' x y rg b
        OP_FILL   = 8'h46,  // 'F' rg b
        OP_ENABLE = 8'h45,  // 'E' channel mask
        OP_PLANES = 8'h42   // 'B' plane mask
    } cmd_op_t;

    typedef enum logic {
        REG_RGB_ENABLE   = 1'b0,
        REG_PLANE_ENABLE = 1'b1
    } reg_sel_t;

endpackage
